//--- tb.f
hdl/zynq_bridge_pkg.sv
hdl/shell_csr_regs.sv
hdl/host_window_xlate.sv
hdl/bp_io_router.sv
hdl/dram_addr_xlate.sv
hdl/mem_region_profiler.sv
hdl/zynq_bridge_top.sv
test/zynq_bridge_checker.sv
test/tb_zynq_bridge.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench, then decide pass or fail from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_zynq_bridge \
   -f tb.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
echo "simulation did not complete, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "TESTS FAILED" sim.log && exit 1 ||
grep -q "TESTS PASSED" sim.log || exit 1

//--- test/tb_zynq_bridge.sv
`timescale 1ns/1ps

module tb_zynq_bridge;

   import zynq_bridge_pkg::*;

   localparam int MAILBOX_DEPTH = 4;

   typedef enum {
      OP_CSR_WR, OP_CSR_RD, OP_HOST, OP_HOST_GATED, OP_IO, OP_IO_FULL,
      OP_POP, OP_PROF, OP_DRAM, OP_ERR
   } op_e;

   typedef struct {
      op_e         op;
      logic [31:0] arg;
      logic [31:0] data;
      logic [31:0] exp;
      string       name;
   } step_t;

   logic        aclk_i;
   logic        rst_i;
   csr_req_t    csr_req_i;
   logic [31:0] csr_rdata_o;
   logic        csr_rvalid_o;
   mem_req_t    host_req_i;
   mem_req_t    bp_host_req_o;
   host_win_e   bp_host_win_o;
   mem_req_t    bp_io_req_i;
   logic        bp_io_ready_o;
   mem_req_t    io_req_o;
   logic        io_ready_i;
   mem_req_t    bp_dram_req_i;
   logic        bp_dram_ready_o;
   mem_req_t    dram_req_o;
   logic        dram_ready_i;
   logic        dram_range_err_o;

   step_t steps [$];
   int    cycles = 0;
   int    limit = 1000000;

   zynq_bridge_top #(.MAILBOX_DEPTH(MAILBOX_DEPTH)) DUT (.*);

   zynq_bridge_checker #(.MAILBOX_DEPTH(MAILBOX_DEPTH)) u_check (
      .csr_rdata_i      (csr_rdata_o),
      .csr_rvalid_i     (csr_rvalid_o),
      .bp_host_req_i    (bp_host_req_o),
      .bp_host_win_i    (bp_host_win_o),
      .bp_io_ready_i    (bp_io_ready_o),
      .io_req_i         (io_req_o),
      .io_ready_i       (io_ready_i),
      .bp_dram_ready_i  (bp_dram_ready_o),
      .dram_req_i       (dram_req_o),
      .dram_ready_i     (dram_ready_i),
      .dram_range_err_i (dram_range_err_o)
   );

   initial begin
      aclk_i = 1'b0;
      forever #50 aclk_i = ~aclk_i;
   end

   always @(posedge aclk_i) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout: the run did not finish within %0d cycles", limit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic add(input op_e op, input logic [31:0] arg, input logic [31:0] data,
                      input logic [31:0] exp, input string name);
      step_t s;
      s.op = op;
      s.arg = arg;
      s.data = data;
      s.exp = exp;
      s.name = name;
      steps.push_back(s);
   endtask

   task automatic build_table();
      add(OP_HOST_GATED, 32'h0000_0100, 0, 0, "host request held by processor reset");
      add(OP_CSR_WR, CSR_RESET, 1, 0, "release processor reset");
      add(OP_HOST, 32'h0000_1000, 0, 0, "host dram window low");
      add(OP_HOST, 32'h1FFF_FFFC, 0, 0, "host dram window top");
      add(OP_HOST, 32'h2000_0000, 0, 0, "host local window base");
      add(OP_HOST, 32'h3000_0040, 0, 0, "host local window");
      add(OP_CSR_WR, CSR_DRAM_ALLOC, 1, 0, "write dram alloc");
      add(OP_CSR_RD, CSR_DRAM_ALLOC, 0, 1, "read dram alloc");
      add(OP_CSR_WR, CSR_DRAM_BASE, 32'h0400_0000, 0, "write dram base");
      add(OP_CSR_RD, CSR_DRAM_BASE, 0, 32'h0400_0000, "read dram base");
      add(OP_CSR_RD, 3, 0, 0, "unmapped index 3");
      add(OP_CSR_RD, 12, 0, 0, "unmapped index 12");
      add(OP_CSR_RD, 63, 0, 0, "unmapped index 63");
      add(OP_IO, 32'h0000_0100, 0, 0, "mailbox push 1");
      add(OP_IO, 32'h0000_0104, 0, 0, "mailbox push 2");
      add(OP_IO, 32'h001F_FFFC, 0, 0, "mailbox push 3");
      add(OP_IO, 32'h0000_0000, 0, 0, "mailbox push 4");
      add(OP_CSR_RD, CSR_MAILBOX_CNT, 0, 4, "mailbox count full");
      add(OP_IO_FULL, 32'h0000_0200, 0, 0, "mailbox back-pressure");
      add(OP_POP, 0, 0, 0, "mailbox pop 1");
      add(OP_POP, 0, 0, 0, "mailbox pop 2");
      add(OP_CSR_RD, CSR_MAILBOX_CNT, 0, 2, "mailbox count half");
      add(OP_POP, 0, 0, 0, "mailbox pop 3");
      add(OP_POP, 0, 0, 0, "mailbox pop 4");
      add(OP_POP, 0, 0, 0, "mailbox pop when empty");
      add(OP_CSR_RD, CSR_MAILBOX_CNT, 0, 0, "mailbox count empty");
      add(OP_IO, 32'h0020_0000, 0, 0, "outbound io at split");
      add(OP_IO, 32'h4000_0000, 0, 0, "outbound io high");
      add(OP_DRAM, 32'h8000_1000, 0, 0, "dram region 0");
      add(OP_DRAM, 32'h8080_0000, 0, 0, "dram region 1");
      add(OP_DRAM, 32'h8500_0000, 0, 0, "dram region 10");
      add(OP_DRAM, 32'h8FF0_0000, 0, 0, "dram region 31 below limit");
      for (int w = 0; w < 4; w++) begin
         add(OP_PROF, w, 0, 0, $sformatf("profile word %0d", w));
      end
      add(OP_DRAM, 32'hA000_0000, 0, 1, "dram above limit");
      add(OP_ERR, 0, 0, 1, "range error stays set");
      add(OP_PROF, 2, 0, 0, "profile word 2 after high access");
      add(OP_CSR_WR, CSR_RESET, 0, 0, "hold processor reset");
      add(OP_CSR_WR, CSR_RESET, 1, 0, "release processor reset again");
      add(OP_ERR, 0, 0, 0, "range error cleared");
      add(OP_PROF, 0, 0, 0, "profile word 0 cleared");
      add(OP_PROF, 2, 0, 0, "profile word 2 cleared");
   endtask

   // ready drops now and then but never for more than three cycles in a row
   function automatic logic pick_ready(input int stalls);
      if (stalls >= 3) begin
         return 1'b1;
      end
      return ($urandom % 3) != 0;
   endfunction

   task automatic csr_read(input logic [5:0] idx, input logic [31:0] exp);
      csr_req_i = '{valid: 1'b1, write: 1'b0, idx: csr_idx_e'(idx), data: '0};
      @(posedge aclk_i);
      #5;
      csr_req_i = '0;
      @(negedge aclk_i);
      u_check.check_csr_resp(exp);
   endtask

   task automatic apply_step(input int i);
      step_t       s;
      logic [31:0] d;
      logic        fire;
      int          stalls;
      s = steps[i];
      d = $urandom;
      fire = 1'b0;
      stalls = 0;
      case (s.op)
         OP_CSR_WR: begin
            csr_req_i = '{valid: 1'b1, write: 1'b1, idx: csr_idx_e'(s.arg[5:0]), data: s.data};
            @(posedge aclk_i);
            #5;
            csr_req_i = '0;
            u_check.note_csr_write(s.arg[5:0], s.data);
            @(negedge aclk_i);
            u_check.check_no_resp();
         end
         OP_CSR_RD: csr_read(s.arg[5:0], s.exp);
         OP_POP: csr_read(6'(CSR_MAILBOX_POP), u_check.pop_expected());
         OP_PROF: csr_read(6'(CSR_PROFILE0) + s.arg[5:0], u_check.prof_word(int'(s.arg)));
         OP_HOST, OP_HOST_GATED: begin
            host_req_i = '{valid: 1'b1, write: d[0], addr: s.arg, data: d};
            @(posedge aclk_i);
            #5;
            host_req_i = '0;
            @(negedge aclk_i);
            if (s.op == OP_HOST) begin
               u_check.check_host(s.arg, d, d[0]);
            end else begin
               u_check.check_host_idle();
            end
            @(negedge aclk_i);
            u_check.check_host_idle();
         end
         OP_IO: begin
            bp_io_req_i = '{valid: 1'b1, write: d[0], addr: s.arg, data: d};
            io_ready_i = pick_ready(stalls);
            while (!fire) begin
               @(negedge aclk_i);
               u_check.check_io(s.arg, d, d[0], fire);
               @(posedge aclk_i);
               #5;
               stalls++;
               io_ready_i = pick_ready(stalls);
            end
            bp_io_req_i = '0;
            io_ready_i = 1'b1;
         end
         OP_IO_FULL: begin
            bp_io_req_i = '{valid: 1'b1, write: 1'b1, addr: s.arg, data: d};
            @(negedge aclk_i);
            u_check.check_io_full();
            @(posedge aclk_i);
            #5;
            bp_io_req_i = '0;
         end
         OP_DRAM: begin
            bp_dram_req_i = '{valid: 1'b1, write: d[0], addr: s.arg, data: d};
            dram_ready_i = pick_ready(stalls);
            while (!fire) begin
               @(negedge aclk_i);
               u_check.check_dram(s.arg, d, d[0], fire);
               @(posedge aclk_i);
               #5;
               stalls++;
               dram_ready_i = pick_ready(stalls);
            end
            bp_dram_req_i = '0;
            dram_ready_i = 1'b1;
            @(negedge aclk_i);
            u_check.check_err(s.exp[0]);
         end
         default: begin
            @(negedge aclk_i);
            u_check.check_err(s.exp[0]);
         end
      endcase
      @(posedge aclk_i);
      #5;
      u_check.finish_test(i, s.name);
   endtask

   initial begin
      void'($urandom(32'hd5ef7596));
      rst_i = 1'b1;
      csr_req_i = '0;
      host_req_i = '0;
      bp_io_req_i = '0;
      bp_dram_req_i = '0;
      io_ready_i = 1'b1;
      dram_ready_i = 1'b1;
      build_table();
      limit = 40 * steps.size() + 200;
      repeat (16) @(posedge aclk_i);
      #5;
      rst_i = 1'b0;
      foreach (steps[i]) begin
         apply_step(i);
      end
      $display("summary: %0d passed, %0d failed", u_check.pass_cnt, u_check.fail_cnt);
      if (u_check.fail_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- test/zynq_bridge_checker.sv
`timescale 1ns/1ps

module zynq_bridge_checker #(
   parameter int MAILBOX_DEPTH = 4
) (
   input  logic [zynq_bridge_pkg::DATA_W-1:0] csr_rdata_i,
   input  logic                               csr_rvalid_i,
   input  zynq_bridge_pkg::mem_req_t          bp_host_req_i,
   input  zynq_bridge_pkg::host_win_e         bp_host_win_i,
   input  logic                               bp_io_ready_i,
   input  zynq_bridge_pkg::mem_req_t          io_req_i,
   input  logic                               io_ready_i,
   input  logic                               bp_dram_ready_i,
   input  zynq_bridge_pkg::mem_req_t          dram_req_i,
   input  logic                               dram_ready_i,
   input  logic                               dram_range_err_i
);

   import zynq_bridge_pkg::*;

   int          pass_cnt = 0;
   int          fail_cnt = 0;
   int          step_errs = 0;
   logic [31:0] mbox_q [$];
   logic [31:0] base_m = '0;
   logic [127:0] profile_m = '0;

   task automatic check(input string label, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s got %h expected %h", $time, label, got, exp);
         step_errs++;
      end
   endtask

   task automatic finish_test(input int num, input string name);
      if (step_errs == 0) begin
         pass_cnt++;
         $display("test %0d %s: ok", num, name);
      end else begin
         fail_cnt++;
         $display("test %0d %s: failed with %0d mismatches", num, name, step_errs);
      end
      step_errs = 0;
   endtask

   // track the registers that shape later responses
   task automatic note_csr_write(input logic [5:0] idx, input logic [31:0] data);
      if (idx == 6'(CSR_DRAM_BASE)) begin
         base_m = data;
      end
      // a cleared reset bit holds the processor side, which empties mailbox and profile
      if (idx == 6'(CSR_RESET) && !data[0]) begin
         mbox_q.delete();
         profile_m = '0;
      end
   endtask

   function automatic logic [31:0] host_addr(input logic [31:0] addr);
      if (addr < HOST_DRAM_WIN_END) begin
         return addr + BP_DRAM_OFFSET;
      end
      return addr - HOST_LOCAL_OFFSET;
   endfunction

   function automatic logic [31:0] pop_expected();
      if (mbox_q.size() == 0) begin
         return '0;
      end
      return mbox_q.pop_front();
   endfunction

   function automatic logic [31:0] prof_word(input int w);
      return profile_m[w*32 +: 32];
   endfunction

   task automatic check_host(input logic [31:0] addr, input logic [31:0] data, input logic wr);
      check("host valid", 32'(bp_host_req_i.valid), 32'd1);
      check("host addr", bp_host_req_i.addr, host_addr(addr));
      check("host data", bp_host_req_i.data, data);
      check("host write", 32'(bp_host_req_i.write), 32'(wr));
      check("host window", 32'(bp_host_win_i),
            (addr < HOST_DRAM_WIN_END) ? 32'(WIN_DRAM) : 32'(WIN_LOCAL));
   endtask

   task automatic check_host_idle();
      check("host valid while idle", 32'(bp_host_req_i.valid), 32'd0);
   endtask

   task automatic check_csr_resp(input logic [31:0] exp);
      check("csr rvalid", 32'(csr_rvalid_i), 32'd1);
      check("csr rdata", csr_rdata_i, exp);
   endtask

   task automatic check_no_resp();
      check("csr rvalid after write", 32'(csr_rvalid_i), 32'd0);
   endtask

   task automatic check_io(input logic [31:0] addr, input logic [31:0] data, input logic wr,
                           output logic fire);
      if (addr < BP_HOST_SPLIT) begin
         fire = mbox_q.size() < MAILBOX_DEPTH;
         check("mailbox ready", 32'(bp_io_ready_i), 32'(fire));
         check("io valid on mailbox push", 32'(io_req_i.valid), 32'd0);
         if (fire) begin
            mbox_q.push_back(data);
         end
      end else begin
         fire = io_ready_i;
         check("io valid", 32'(io_req_i.valid), 32'd1);
         check("io addr", io_req_i.addr, addr);
         check("io data", io_req_i.data, data);
         check("io write", 32'(io_req_i.write), 32'(wr));
         check("io ready", 32'(bp_io_ready_i), 32'(io_ready_i));
      end
   endtask

   task automatic check_io_full();
      check("ready with full mailbox", 32'(bp_io_ready_i), 32'd0);
   endtask

   task automatic check_dram(input logic [31:0] addr, input logic [31:0] data, input logic wr,
                             output logic fire);
      check("dram valid", 32'(dram_req_i.valid), 32'd1);
      check("dram addr", dram_req_i.addr, (addr ^ BP_DRAM_OFFSET) + base_m);
      check("dram data", dram_req_i.data, data);
      check("dram write", 32'(dram_req_i.write), 32'(wr));
      check("dram ready", 32'(bp_dram_ready_i), 32'(dram_ready_i));
      fire = dram_ready_i;
      if (fire) begin
         profile_m[addr[29:23]] = 1'b1;
      end
   endtask

   task automatic check_err(input logic exp);
      check("dram range error", 32'(dram_range_err_i), 32'(exp));
   endtask

endmodule

//--- hdl/zynq_bridge_top.sv
`timescale 1ns/1ps

module zynq_bridge_top #(
   parameter int MAILBOX_DEPTH = 4
) (
   input  logic                                aclk_i,
   input  logic                                rst_i,

   input  zynq_bridge_pkg::csr_req_t           csr_req_i,
   output logic [zynq_bridge_pkg::DATA_W-1:0]  csr_rdata_o,
   output logic                                csr_rvalid_o,

   input  zynq_bridge_pkg::mem_req_t           host_req_i,
   output zynq_bridge_pkg::mem_req_t           bp_host_req_o,
   output zynq_bridge_pkg::host_win_e          bp_host_win_o,

   input  zynq_bridge_pkg::mem_req_t           bp_io_req_i,
   output logic                                bp_io_ready_o,
   output zynq_bridge_pkg::mem_req_t           io_req_o,
   input  logic                                io_ready_i,

   input  zynq_bridge_pkg::mem_req_t           bp_dram_req_i,
   output logic                                bp_dram_ready_o,
   output zynq_bridge_pkg::mem_req_t           dram_req_o,
   input  logic                                dram_ready_i,

   output logic                                dram_range_err_o
);

   import zynq_bridge_pkg::*;

   logic                       bp_rst;
   logic [DATA_W-1:0]          dram_base;
   logic [DATA_W-1:0]          mbox_head;
   logic [3:0]                 mbox_count;
   logic                       mbox_pop;
   logic [PROFILE_REGIONS-1:0] profile;
   logic                       dram_fire;

   // the profiler counts a DRAM request only once the memory side takes it
   assign dram_fire = bp_dram_req_i.valid & bp_dram_ready_o;

   shell_csr_regs u_csr (
      .aclk_i       (aclk_i),
      .rst_i        (rst_i),
      .csr_req_i    (csr_req_i),
      .mbox_head_i  (mbox_head),
      .mbox_count_i (mbox_count),
      .profile_i    (profile),
      .mbox_pop_o   (mbox_pop),
      .csr_rdata_o  (csr_rdata_o),
      .csr_rvalid_o (csr_rvalid_o),
      .bp_rst_o     (bp_rst),
      .dram_base_o  (dram_base)
   );

   host_window_xlate u_host_xlate (
      .aclk_i        (aclk_i),
      .bp_rst_i      (bp_rst),
      .host_req_i    (host_req_i),
      .bp_host_req_o (bp_host_req_o),
      .bp_host_win_o (bp_host_win_o)
   );

   bp_io_router #(
      .MAILBOX_DEPTH (MAILBOX_DEPTH)
   ) u_io_router (
      .aclk_i        (aclk_i),
      .bp_rst_i      (bp_rst),
      .bp_io_req_i   (bp_io_req_i),
      .io_ready_i    (io_ready_i),
      .mbox_pop_i    (mbox_pop),
      .bp_io_ready_o (bp_io_ready_o),
      .io_req_o      (io_req_o),
      .mbox_head_o   (mbox_head),
      .mbox_count_o  (mbox_count)
   );

   dram_addr_xlate u_dram_xlate (
      .aclk_i           (aclk_i),
      .bp_rst_i         (bp_rst),
      .bp_dram_req_i    (bp_dram_req_i),
      .dram_ready_i     (dram_ready_i),
      .dram_base_i      (dram_base),
      .bp_dram_ready_o  (bp_dram_ready_o),
      .dram_req_o       (dram_req_o),
      .dram_range_err_o (dram_range_err_o)
   );

   mem_region_profiler u_profiler (
      .aclk_i      (aclk_i),
      .bp_rst_i    (bp_rst),
      .dram_req_i  (bp_dram_req_i),
      .dram_fire_i (dram_fire),
      .profile_o   (profile)
   );

endmodule

//--- hdl/mem_region_profiler.sv
`timescale 1ns/1ps

module mem_region_profiler (
   input  logic                                        aclk_i,
   input  logic                                        bp_rst_i,
   input  zynq_bridge_pkg::mem_req_t                   dram_req_i,
   input  logic                                        dram_fire_i,
   output logic [zynq_bridge_pkg::PROFILE_REGIONS-1:0] profile_o
);

   import zynq_bridge_pkg::*;

   localparam int REGION_W = $clog2(PROFILE_REGIONS);

   logic [REGION_W-1:0]        region;
   logic [PROFILE_REGIONS-1:0] profile_q;

   // processor address, before rebasing onto the host buffer
   assign region = dram_req_i.addr[29 -: REGION_W];

   always_ff @(posedge aclk_i) begin
      if (bp_rst_i) begin
         profile_q <= '0;
      end else if (dram_fire_i) begin
         profile_q <= profile_q | (PROFILE_REGIONS'(1) << region);
      end
   end

   assign profile_o = profile_q;

   a_clear_on_reset: assert property (
      @(posedge aclk_i) bp_rst_i |=> profile_o == '0
   );

endmodule

//--- hdl/dram_addr_xlate.sv
`timescale 1ns/1ps

module dram_addr_xlate (
   input  logic                               aclk_i,
   input  logic                               bp_rst_i,
   input  zynq_bridge_pkg::mem_req_t          bp_dram_req_i,
   input  logic                               dram_ready_i,
   input  logic [zynq_bridge_pkg::DATA_W-1:0] dram_base_i,
   output logic                               bp_dram_ready_o,
   output zynq_bridge_pkg::mem_req_t          dram_req_o,
   output logic                               dram_range_err_o
);

   import zynq_bridge_pkg::*;

   logic [ADDR_W-1:0] offset;
   logic              range_err_q;

   // strip the processor DRAM base, then move onto the host-allocated buffer
   assign offset          = bp_dram_req_i.addr ^ BP_DRAM_OFFSET;
   assign bp_dram_ready_o = dram_ready_i;

   always_comb begin
      dram_req_o      = bp_dram_req_i;
      dram_req_o.addr = offset + dram_base_i;
   end

   // sticky until the processor side is reset by the host
   always_ff @(posedge aclk_i) begin
      if (bp_rst_i) begin
         range_err_q <= 1'b0;
      end else if (bp_dram_req_i.valid && (offset >= MEM_LIMIT)) begin
         range_err_q <= 1'b1;
      end
   end

   assign dram_range_err_o = range_err_q;

endmodule

//--- hdl/bp_io_router.sv
`timescale 1ns/1ps

module bp_io_router #(
   parameter int MAILBOX_DEPTH = 4
) (
   input  logic                               aclk_i,
   input  logic                               bp_rst_i,
   input  zynq_bridge_pkg::mem_req_t          bp_io_req_i,
   input  logic                               io_ready_i,
   input  logic                               mbox_pop_i,
   output logic                               bp_io_ready_o,
   output zynq_bridge_pkg::mem_req_t          io_req_o,
   output logic [zynq_bridge_pkg::DATA_W-1:0] mbox_head_o,
   output logic [3:0]                         mbox_count_o
);

   import zynq_bridge_pkg::*;

   localparam int PTR_W = (MAILBOX_DEPTH > 1) ? $clog2(MAILBOX_DEPTH) : 1;
   localparam logic [3:0] DEPTH_C = 4'(MAILBOX_DEPTH);

   logic [DATA_W-1:0] mbox_mem [MAILBOX_DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [3:0]        count;
   logic              to_host;
   logic              full;
   logic              push;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(MAILBOX_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // the low address range belongs to the host, everything else leaves on the I/O port
   assign to_host       = bp_io_req_i.addr < BP_HOST_SPLIT;
   assign full          = count == DEPTH_C;
   assign bp_io_ready_o = to_host ? ~full : io_ready_i;
   assign push          = bp_io_req_i.valid & to_host & bp_io_ready_o;

   always_comb begin
      io_req_o       = bp_io_req_i;
      io_req_o.valid = bp_io_req_i.valid & ~to_host;
   end

   always_ff @(posedge aclk_i) begin
      if (bp_rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (mbox_pop_i) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count <= count + 4'(push) - 4'(mbox_pop_i);
      end
   end

   // only the data word is kept, the host sees it in arrival order
   always_ff @(posedge aclk_i) begin
      if (push) begin
         mbox_mem[wr_ptr] <= bp_io_req_i.data;
      end
   end

   assign mbox_head_o  = mbox_mem[rd_ptr];
   assign mbox_count_o = count;

   // a push into a full mailbox would carry the occupancy past the depth
   a_no_push_full: assert property (
      @(posedge aclk_i) disable iff (bp_rst_i) count <= DEPTH_C
   );

   // the pop comes from the CSR block, which must see a nonzero count
   a_no_pop_empty: assert property (
      @(posedge aclk_i) disable iff (bp_rst_i) mbox_pop_i |-> count != 4'd0
   );

endmodule

//--- hdl/host_window_xlate.sv
`timescale 1ns/1ps

module host_window_xlate (
   input  logic                        aclk_i,
   input  logic                        bp_rst_i,
   input  zynq_bridge_pkg::mem_req_t   host_req_i,
   output zynq_bridge_pkg::mem_req_t   bp_host_req_o,
   output zynq_bridge_pkg::host_win_e  bp_host_win_o
);

   import zynq_bridge_pkg::*;

   logic              in_dram;
   logic [ADDR_W-1:0] addr_d;
   logic              valid_q;
   logic              write_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] data_q;
   host_win_e         win_q;

   // low host window maps onto processor DRAM, the upper one onto local space
   assign in_dram = host_req_i.addr < HOST_DRAM_WIN_END;
   assign addr_d  = in_dram ? host_req_i.addr + BP_DRAM_OFFSET
                            : host_req_i.addr - HOST_LOCAL_OFFSET;

   always_ff @(posedge aclk_i) begin
      if (bp_rst_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= host_req_i.valid;
      end
      if (host_req_i.valid) begin
         write_q <= host_req_i.write;
         addr_q  <= addr_d;
         data_q  <= host_req_i.data;
         win_q   <= in_dram ? WIN_DRAM : WIN_LOCAL;
      end
   end

   assign bp_host_req_o = '{valid: valid_q, write: write_q, addr: addr_q, data: data_q};
   assign bp_host_win_o = win_q;

endmodule

//--- hdl/shell_csr_regs.sv
`timescale 1ns/1ps

module shell_csr_regs (
   input  logic                                        aclk_i,
   input  logic                                        rst_i,
   input  zynq_bridge_pkg::csr_req_t                   csr_req_i,
   input  logic [zynq_bridge_pkg::DATA_W-1:0]          mbox_head_i,
   input  logic [3:0]                                  mbox_count_i,
   input  logic [zynq_bridge_pkg::PROFILE_REGIONS-1:0] profile_i,
   output logic                                        mbox_pop_o,
   output logic [zynq_bridge_pkg::DATA_W-1:0]          csr_rdata_o,
   output logic                                        csr_rvalid_o,
   output logic                                        bp_rst_o,
   output logic [zynq_bridge_pkg::DATA_W-1:0]          dram_base_o
);

   import zynq_bridge_pkg::*;

   logic              reset_q;
   logic              dram_alloc_q;
   logic [DATA_W-1:0] dram_base_q;
   logic              rd_stb;
   logic              wr_stb;
   logic [DATA_W-1:0] rdata_d;
   logic [DATA_W-1:0] rdata_q;
   logic              rvalid_q;

   assign rd_stb = csr_req_i.valid & ~csr_req_i.write;
   assign wr_stb = csr_req_i.valid & csr_req_i.write;

   // the processor side stays in reset until the host sets bit 0 of CSR_RESET
   assign bp_rst_o    = rst_i | ~reset_q;
   assign dram_base_o = dram_base_q;

   // an empty mailbox is read as 0 and is not popped
   assign mbox_pop_o = rd_stb && (csr_req_i.idx == CSR_MAILBOX_POP) && (mbox_count_i != 4'd0);

   always_ff @(posedge aclk_i) begin
      if (rst_i) begin
         reset_q      <= 1'b0;
         dram_alloc_q <= 1'b0;
         dram_base_q  <= '0;
      end else if (wr_stb) begin
         case (csr_req_i.idx)
            CSR_RESET:      reset_q      <= csr_req_i.data[0];
            CSR_DRAM_ALLOC: dram_alloc_q <= csr_req_i.data[0];
            CSR_DRAM_BASE:  dram_base_q  <= csr_req_i.data;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (csr_req_i.idx)
         CSR_RESET:       rdata_d = DATA_W'(reset_q);
         CSR_DRAM_ALLOC:  rdata_d = DATA_W'(dram_alloc_q);
         CSR_DRAM_BASE:   rdata_d = dram_base_q;
         CSR_MAILBOX_POP: rdata_d = (mbox_count_i != 4'd0) ? mbox_head_i : '0;
         CSR_MAILBOX_CNT: rdata_d = DATA_W'(mbox_count_i);
         CSR_PROFILE0:    rdata_d = profile_i[0*DATA_W +: DATA_W];
         CSR_PROFILE1:    rdata_d = profile_i[1*DATA_W +: DATA_W];
         CSR_PROFILE2:    rdata_d = profile_i[2*DATA_W +: DATA_W];
         CSR_PROFILE3:    rdata_d = profile_i[3*DATA_W +: DATA_W];
         default:         rdata_d = '0;
      endcase
   end

   always_ff @(posedge aclk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_stb;
      end
      if (rd_stb) begin
         rdata_q <= rdata_d;
      end
   end

   assign csr_rdata_o  = rdata_q;
   assign csr_rvalid_o = rvalid_q;

   // a host write never produces a read response
   a_no_rvalid_after_write: assert property (
      @(posedge aclk_i) disable iff (rst_i)
      wr_stb |=> !csr_rvalid_o
   );

endmodule

//--- hdl/zynq_bridge_pkg.sv
package zynq_bridge_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // host addresses below this land in processor DRAM, the rest in local space
   localparam logic [ADDR_W-1:0] HOST_DRAM_WIN_END = 32'h2000_0000;
   localparam logic [ADDR_W-1:0] BP_DRAM_OFFSET    = 32'h8000_0000;
   localparam logic [ADDR_W-1:0] HOST_LOCAL_OFFSET = 32'h2000_0000;

   // processor outbound addresses below this go to the host mailbox
   localparam logic [ADDR_W-1:0] BP_HOST_SPLIT = 32'h0020_0000;

   // size of the host-allocated DRAM buffer
   localparam logic [ADDR_W-1:0] MEM_LIMIT = 32'h1000_0000;

   // one bit per 8 MB region, picked by address bits 29..23
   localparam int PROFILE_REGIONS = 128;

   typedef enum logic [5:0] {
      CSR_RESET       = 6'd0,
      CSR_DRAM_ALLOC  = 6'd1,
      CSR_DRAM_BASE   = 6'd2,
      CSR_MAILBOX_POP = 6'd4,
      CSR_MAILBOX_CNT = 6'd5,
      CSR_PROFILE0    = 6'd8,
      CSR_PROFILE1    = 6'd9,
      CSR_PROFILE2    = 6'd10,
      CSR_PROFILE3    = 6'd11
   } csr_idx_e;

   typedef enum logic {
      WIN_DRAM  = 1'b0,
      WIN_LOCAL = 1'b1
   } host_win_e;

   typedef struct packed {
      logic              valid;
      logic              write;
      csr_idx_e          idx;
      logic [DATA_W-1:0] data;
   } csr_req_t;

   typedef struct packed {
      logic              valid;
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } mem_req_t;

endpackage
